// ==== hdl/cop_pkg.sv ====
/* Encodings shared by the coprocessor subsystem and its testbench:
   opcodes, function codes, coprocessor numbers and the CSR window */
package cop_pkg;

    // Fixed by the RISC-V instruction encoding
    localparam int INST_WIDTH = 32;

    // Major opcodes routed to the coprocessors
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
    localparam logic [6:0] OPC_FP     = 7'b1010011;
    localparam logic [6:0] OPC_CUSTOM = 7'b0001011;

    // Coprocessor numbers
    typedef enum logic [1:0] {
        CP_CSR      = 2'd0,
        CP_MUL      = 2'd1,
        CP_BITMANIP = 2'd2
    } cp_sel_e;

    // CP0 access codes in funct3
    localparam logic [2:0] F3_CSRRW = 3'b001;
    localparam logic [2:0] F3_CSRRS = 3'b010;
    localparam logic [2:0] F3_CSRRC = 3'b011;

    // CP1 result half
    localparam logic [2:0] F3_MUL_LO = 3'b000;
    localparam logic [2:0] F3_MUL_HI = 3'b001;

    // CP2 operations
    localparam logic [2:0] F3_POPCNT = 3'b000;
    localparam logic [2:0] F3_BREV   = 3'b001;
    localparam logic [2:0] F3_CLZ    = 3'b010;

    // CSR window, CSR_COUNT registers starting at CSR_BASE
    localparam logic [11:0] CSR_BASE  = 12'h340;
    localparam int          CSR_COUNT = 4;

endpackage

// ==== hdl/cop_dispatcher.sv ====
/* Input side of the coprocessor subsystem. Decodes the opcode, starts
   one coprocessor and stalls the CPU until the result is back */
`timescale 1ns/100ps

module cop_dispatcher #(
    parameter int DATA_WIDTH = 64
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [cop_pkg::INST_WIDTH-1:0] instruction,
    input  logic                          inst_valid,
    input  logic                          pipeline_stall,
    input  logic [DATA_WIDTH-1:0]         rs1_data,
    input  logic [DATA_WIDTH-1:0]         rs2_data,
    input  logic                          cp_ready,
    output logic                          start_csr,
    output logic                          start_mul,
    output logic                          start_bitmanip,
    output logic                          cp_instruction_detected,
    output logic                          cp_stall_request,
    output cop_pkg::cp_sel_e              cp_select,
    output logic [cop_pkg::INST_WIDTH-1:0] op_instruction,
    output logic [DATA_WIDTH-1:0]         op_a,
    output logic [DATA_WIDTH-1:0]         op_b
);

    logic [6:0]       opcode;
    cop_pkg::cp_sel_e sel_q;

    assign opcode = instruction[6:0];

    // Opcode decode, nothing is detected while the pipeline stalls
    always_comb begin
        cp_instruction_detected = 1'b0;
        cp_select = cop_pkg::CP_CSR;
        if (inst_valid && !pipeline_stall) begin
            case (opcode)
                cop_pkg::OPC_SYSTEM: begin
                    cp_instruction_detected = 1'b1;
                    cp_select = cop_pkg::CP_CSR;
                end
                cop_pkg::OPC_FP: begin
                    cp_instruction_detected = 1'b1;
                    cp_select = cop_pkg::CP_MUL;
                end
                cop_pkg::OPC_CUSTOM: begin
                    cp_instruction_detected = 1'b1;
                    cp_select = cop_pkg::CP_BITMANIP;
                end
                default: begin
                    cp_instruction_detected = 1'b0;
                end
            endcase
        end
    end

    // One-hot strobes, held as long as the instruction is
    assign start_csr      = cp_instruction_detected && (cp_select == cop_pkg::CP_CSR);
    assign start_mul      = cp_instruction_detected && (cp_select == cop_pkg::CP_MUL);
    assign start_bitmanip = cp_instruction_detected && (cp_select == cop_pkg::CP_BITMANIP);

    assign cp_stall_request = cp_instruction_detected && !cp_ready;

    assign op_instruction = instruction;
    assign op_a = rs1_data;
    assign op_b = rs2_data;

    // Last selected coprocessor
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sel_q <= cop_pkg::CP_CSR;
        end else if (cp_instruction_detected) begin
            sel_q <= cp_select;
        end
    end

endmodule

// ==== hdl/csr_unit.sv ====
/* CP0, four control/status registers with read-write, set and clear
   access. Returns the old value one cycle after start */
`timescale 1ns/100ps

module csr_unit #(
    parameter int DATA_WIDTH = 64
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    input  logic [cop_pkg::INST_WIDTH-1:0] op_instruction,
    input  logic [DATA_WIDTH-1:0]         op_a,
    output logic                          done,
    output logic                          exception,
    output logic [DATA_WIDTH-1:0]         result
);

    localparam int IW = $clog2(cop_pkg::CSR_COUNT);

    logic [DATA_WIDTH-1:0] csr [cop_pkg::CSR_COUNT];
    logic [11:0]           offset;
    logic [IW-1:0]         idx;
    logic [2:0]            f3;
    logic                  in_range;
    logic                  known_op;
    logic                  accept;

    assign f3       = op_instruction[14:12];
    assign offset   = op_instruction[31:20] - cop_pkg::CSR_BASE;
    assign in_range = offset < 12'(cop_pkg::CSR_COUNT);
    assign idx      = offset[IW-1:0];
    assign known_op = (f3 == cop_pkg::F3_CSRRW) || (f3 == cop_pkg::F3_CSRRS) ||
                      (f3 == cop_pkg::F3_CSRRC);

    // Done cycle counts as busy so a held strobe does not rerun the access
    assign accept = start && !done;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done      <= 1'b0;
            exception <= 1'b0;
            for (int i = 0; i < cop_pkg::CSR_COUNT; i++) begin
                csr[i] <= '0;
            end
        end else begin
            done <= accept;
            if (accept) begin
                exception <= !(in_range && known_op);
                if (in_range && known_op) begin
                    case (f3)
                        cop_pkg::F3_CSRRW: csr[idx] <= op_a;
                        cop_pkg::F3_CSRRS: csr[idx] <= csr[idx] | op_a;
                        default:           csr[idx] <= csr[idx] & ~op_a;
                    endcase
                end
            end
        end
    end

    // Old value of the addressed CSR
    always_ff @(posedge clk) begin
        if (accept) begin
            result <= (in_range && known_op) ? csr[idx] : '0;
        end
    end

endmodule

// ==== hdl/mul_unit.sv ====
/* CP1, unsigned shift-add multiplier retiring one multiplier bit per
   cycle. Returns the low or high half of the product */
`timescale 1ns/100ps

module mul_unit #(
    parameter int DATA_WIDTH = 64
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    input  logic [cop_pkg::INST_WIDTH-1:0] op_instruction,
    input  logic [DATA_WIDTH-1:0]         op_a,
    input  logic [DATA_WIDTH-1:0]         op_b,
    output logic                          done,
    output logic                          exception,
    output logic [DATA_WIDTH-1:0]         result
);

    localparam int CW = $clog2(DATA_WIDTH);

    logic [2*DATA_WIDTH-1:0] acc;
    logic [2*DATA_WIDTH-1:0] mcand;
    logic [DATA_WIDTH-1:0]   mplier;
    logic [CW-1:0]           cnt;
    logic [2:0]              f3;
    logic                    busy;
    logic                    hi_sel;
    logic                    legal;
    logic                    accept;

    assign f3     = op_instruction[14:12];
    assign legal  = (f3 == cop_pkg::F3_MUL_LO) || (f3 == cop_pkg::F3_MUL_HI);
    assign accept = start && !busy && !done;

    // Sequencing, illegal codes finish at once
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            done      <= 1'b0;
            exception <= 1'b0;
            cnt       <= '0;
        end else begin
            done <= 1'b0;
            if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == CW'(DATA_WIDTH - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end else if (accept) begin
                busy      <= legal;
                done      <= !legal;
                exception <= !legal;
                cnt       <= '0;
            end
        end
    end

    // Shift-add datapath
    always_ff @(posedge clk) begin
        if (accept) begin
            acc    <= '0;
            mcand  <= {{DATA_WIDTH{1'b0}}, op_a};
            mplier <= op_b;
            hi_sel <= (f3 == cop_pkg::F3_MUL_HI);
        end else if (busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign result = hi_sel ? acc[2*DATA_WIDTH-1:DATA_WIDTH] : acc[DATA_WIDTH-1:0];

endmodule

// ==== hdl/bitmanip_unit.sv ====
/* CP2, two-stage bit-manipulation unit with popcount, bit reverse and
   leading-zero count */
`timescale 1ns/100ps

module bitmanip_unit #(
    parameter int DATA_WIDTH = 64
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    input  logic [cop_pkg::INST_WIDTH-1:0] op_instruction,
    input  logic [DATA_WIDTH-1:0]         op_a,
    output logic                          done,
    output logic                          exception,
    output logic [DATA_WIDTH-1:0]         result
);

    logic                  v1;
    logic [DATA_WIDTH-1:0] a1;
    logic [2:0]            f3_1;
    logic [DATA_WIDTH-1:0] pop;
    logic [DATA_WIDTH-1:0] rev;
    logic [DATA_WIDTH-1:0] lz;

    // Stage 1 registers operand and function code
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            v1 <= 1'b0;
        end else begin
            v1 <= start && !v1 && !done;
        end
    end

    always_ff @(posedge clk) begin
        if (start && !v1 && !done) begin
            a1   <= op_a;
            f3_1 <= op_instruction[14:12];
        end
    end

    always_comb begin
        pop = '0;
        lz  = DATA_WIDTH'(DATA_WIDTH);
        for (int i = 0; i < DATA_WIDTH; i++) begin
            pop = pop + DATA_WIDTH'(a1[i]);
            rev[i] = a1[DATA_WIDTH-1-i];
            // Highest set bit wins
            if (a1[i]) begin
                lz = DATA_WIDTH'(DATA_WIDTH - 1 - i);
            end
        end
    end

    // Stage 2 selects the operation
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done      <= 1'b0;
            exception <= 1'b0;
        end else begin
            done <= v1;
            if (v1) begin
                exception <= !(f3_1 == cop_pkg::F3_POPCNT || f3_1 == cop_pkg::F3_BREV ||
                               f3_1 == cop_pkg::F3_CLZ);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (v1) begin
            case (f3_1)
                cop_pkg::F3_POPCNT: result <= pop;
                cop_pkg::F3_BREV:   result <= rev;
                cop_pkg::F3_CLZ:    result <= lz;
                default:            result <= '0;
            endcase
        end
    end

endmodule

// ==== hdl/cop_writeback.sv ====
/* Output side of the coprocessor subsystem. Returns the finishing unit's
   result to the CPU and issues the register write one cycle later */
`timescale 1ns/100ps

module cop_writeback #(
    parameter int DATA_WIDTH = 64
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  cop_pkg::cp_sel_e              cp_select,
    input  logic [cop_pkg::INST_WIDTH-1:0] op_instruction,
    input  logic                          done_csr,
    input  logic                          done_mul,
    input  logic                          done_bitmanip,
    input  logic                          exc_csr,
    input  logic                          exc_mul,
    input  logic                          exc_bitmanip,
    input  logic [DATA_WIDTH-1:0]         res_csr,
    input  logic [DATA_WIDTH-1:0]         res_mul,
    input  logic [DATA_WIDTH-1:0]         res_bitmanip,
    output logic                          cp_ready,
    output logic                          cp_result_valid,
    output logic                          cp_exception_out,
    output logic                          cp_reg_write,
    output logic [DATA_WIDTH-1:0]         cp_result,
    output logic [DATA_WIDTH-1:0]         cp_reg_data,
    output logic [4:0]                    cp_reg_addr
);

    logic [4:0] rd;

    assign rd = op_instruction[11:7];

    assign cp_ready        = done_csr || done_mul || done_bitmanip;
    assign cp_result_valid = cp_ready;

    // Instruction is still held in the done cycle, so cp_select is valid
    always_comb begin
        case (cp_select)
            cop_pkg::CP_MUL: begin
                cp_result        = res_mul;
                cp_exception_out = exc_mul;
            end
            cop_pkg::CP_BITMANIP: begin
                cp_result        = res_bitmanip;
                cp_exception_out = exc_bitmanip;
            end
            default: begin
                cp_result        = res_csr;
                cp_exception_out = exc_csr;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cp_reg_write <= 1'b0;
        end else begin
            cp_reg_write <= cp_ready && !cp_exception_out && (rd != 5'd0);
        end
    end

    always_ff @(posedge clk) begin
        cp_reg_addr <= rd;
        cp_reg_data <= cp_result;
    end

endmodule

// ==== hdl/cop_subsystem.sv ====
/* Top level of the coprocessor subsystem. Connects the dispatcher, the
   three coprocessors and the writeback stage */
`timescale 1ns/100ps

module cop_subsystem #(
    parameter int DATA_WIDTH = 64
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [cop_pkg::INST_WIDTH-1:0] instruction,
    input  logic                          inst_valid,
    input  logic [DATA_WIDTH-1:0]         rs1_data,
    input  logic [DATA_WIDTH-1:0]         rs2_data,
    input  logic                          pipeline_stall,
    output logic                          cp_instruction_detected,
    output logic                          cp_stall_request,
    output logic [DATA_WIDTH-1:0]         cp_result,
    output logic                          cp_result_valid,
    output logic                          cp_exception_out,
    output logic                          cp_reg_write,
    output logic [4:0]                    cp_reg_addr,
    output logic [DATA_WIDTH-1:0]         cp_reg_data
);

    logic                           start_csr;
    logic                           start_mul;
    logic                           start_bitmanip;
    logic                           cp_ready;
    cop_pkg::cp_sel_e               cp_select;
    logic [cop_pkg::INST_WIDTH-1:0] op_instruction;
    logic [DATA_WIDTH-1:0]          op_a;
    logic [DATA_WIDTH-1:0]          op_b;
    logic                           done_csr;
    logic                           done_mul;
    logic                           done_bitmanip;
    logic                           exc_csr;
    logic                           exc_mul;
    logic                           exc_bitmanip;
    logic [DATA_WIDTH-1:0]          res_csr;
    logic [DATA_WIDTH-1:0]          res_mul;
    logic [DATA_WIDTH-1:0]          res_bitmanip;

    cop_dispatcher #(.DATA_WIDTH(DATA_WIDTH)) u_disp (
        .clk(clk), .rst_n(rst_n),
        .instruction(instruction), .inst_valid(inst_valid),
        .pipeline_stall(pipeline_stall),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .cp_ready(cp_ready),
        .start_csr(start_csr), .start_mul(start_mul), .start_bitmanip(start_bitmanip),
        .cp_instruction_detected(cp_instruction_detected),
        .cp_stall_request(cp_stall_request), .cp_select(cp_select),
        .op_instruction(op_instruction), .op_a(op_a), .op_b(op_b)
    );

    // CP0
    csr_unit #(.DATA_WIDTH(DATA_WIDTH)) u_csr (
        .clk(clk), .rst_n(rst_n), .start(start_csr),
        .op_instruction(op_instruction), .op_a(op_a),
        .done(done_csr), .exception(exc_csr), .result(res_csr)
    );

    // CP1
    mul_unit #(.DATA_WIDTH(DATA_WIDTH)) u_mul (
        .clk(clk), .rst_n(rst_n), .start(start_mul),
        .op_instruction(op_instruction), .op_a(op_a), .op_b(op_b),
        .done(done_mul), .exception(exc_mul), .result(res_mul)
    );

    // CP2
    bitmanip_unit #(.DATA_WIDTH(DATA_WIDTH)) u_bitmanip (
        .clk(clk), .rst_n(rst_n), .start(start_bitmanip),
        .op_instruction(op_instruction), .op_a(op_a),
        .done(done_bitmanip), .exception(exc_bitmanip), .result(res_bitmanip)
    );

    cop_writeback #(.DATA_WIDTH(DATA_WIDTH)) u_wb (
        .clk(clk), .rst_n(rst_n), .cp_select(cp_select),
        .op_instruction(op_instruction),
        .done_csr(done_csr), .done_mul(done_mul), .done_bitmanip(done_bitmanip),
        .exc_csr(exc_csr), .exc_mul(exc_mul), .exc_bitmanip(exc_bitmanip),
        .res_csr(res_csr), .res_mul(res_mul), .res_bitmanip(res_bitmanip),
        .cp_ready(cp_ready), .cp_result_valid(cp_result_valid),
        .cp_exception_out(cp_exception_out), .cp_reg_write(cp_reg_write),
        .cp_result(cp_result), .cp_reg_data(cp_reg_data), .cp_reg_addr(cp_reg_addr)
    );

endmodule

// ==== dv/cop_subsystem_chk.sv ====
/* Protocol assertions for the coprocessor subsystem, attached to the
   top level with bind */
`timescale 1ns/100ps

module cop_subsystem_chk (
    input logic             clk,
    input logic             rst_n,
    input logic             start_csr,
    input logic             start_mul,
    input logic             start_bitmanip,
    input logic             done_csr,
    input logic             done_mul,
    input logic             done_bitmanip,
    input logic             exc_csr,
    input logic             exc_mul,
    input logic             exc_bitmanip,
    input cop_pkg::cp_sel_e cp_select,
    input cop_pkg::cp_sel_e sel_q,
    input logic             cp_instruction_detected,
    input logic             cp_result_valid,
    input logic             cp_reg_write
);

    // Read by the testbench at the end of the run
    int unsigned assert_fails = 0;

    // One coprocessor started and one finishing at a time
    a_one_start: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({start_csr, start_mul, start_bitmanip}) &&
        $onehot0({done_csr, done_mul, done_bitmanip}))
    else begin
        $error("More than one start strobe or done pulse high");
        assert_fails++;
    end

    a_valid_detected: assert property (@(posedge clk) disable iff (!rst_n)
        cp_result_valid |-> cp_instruction_detected)
    else begin
        $error("Result valid without a detected instruction");
        assert_fails++;
    end

    // Result belongs to the coprocessor selected while the instruction was held
    a_same_unit: assert property (@(posedge clk) disable iff (!rst_n)
        cp_result_valid |-> (cp_select == sel_q))
    else begin
        $error("Result from a coprocessor other than the one started");
        assert_fails++;
    end

    // Exception results never reach the register file
    a_no_write_on_exc: assert property (@(posedge clk) disable iff (!rst_n)
        ((done_csr && exc_csr) || (done_mul && exc_mul) ||
         (done_bitmanip && exc_bitmanip)) |=> !cp_reg_write)
    else begin
        $error("Register write after an exception");
        assert_fails++;
    end

endmodule

bind cop_subsystem cop_subsystem_chk chk0 (
    .clk(clk), .rst_n(rst_n),
    .start_csr(start_csr), .start_mul(start_mul), .start_bitmanip(start_bitmanip),
    .done_csr(done_csr), .done_mul(done_mul), .done_bitmanip(done_bitmanip),
    .exc_csr(exc_csr), .exc_mul(exc_mul), .exc_bitmanip(exc_bitmanip),
    .cp_select(cp_select), .sel_q(u_disp.sel_q),
    .cp_instruction_detected(cp_instruction_detected),
    .cp_result_valid(cp_result_valid),
    .cp_reg_write(cp_reg_write)
);

// ==== dv/cop_subsystem_tb.sv ====
/* Testbench for the coprocessor subsystem. Plays the CPU, reads each
   instruction and its expected response from dv/cop_testdata.txt */
`timescale 1ns/100ps

module cop_subsystem_tb;

    localparam int DW           = 64;
    localparam int TIMEOUT      = 200;
    localparam int QUIET_CYCLES = 10;

    logic          clk;
    logic          rst_n;
    logic [31:0]   instruction;
    logic          inst_valid;
    logic [DW-1:0] rs1_data;
    logic [DW-1:0] rs2_data;
    logic          pipeline_stall;
    logic          cp_instruction_detected;
    logic          cp_stall_request;
    logic [DW-1:0] cp_result;
    logic          cp_result_valid;
    logic          cp_exception_out;
    logic          cp_reg_write;
    logic [4:0]    cp_reg_addr;
    logic [DW-1:0] cp_reg_data;

    int pass_count;
    int fail_count;
    int cur_test;
    bit test_ok;

    cop_subsystem #(.DATA_WIDTH(DW)) dut0 (
        .clk(clk), .rst_n(rst_n),
        .instruction(instruction), .inst_valid(inst_valid),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .pipeline_stall(pipeline_stall),
        .cp_instruction_detected(cp_instruction_detected),
        .cp_stall_request(cp_stall_request), .cp_result(cp_result),
        .cp_result_valid(cp_result_valid), .cp_exception_out(cp_exception_out),
        .cp_reg_write(cp_reg_write), .cp_reg_addr(cp_reg_addr), .cp_reg_data(cp_reg_data)
    );

    always #2 clk = ~clk;

    // Cycles from presentation to result, per coprocessor
    function automatic int expected_latency(logic [31:0] ins);
        logic [2:0] f3;
        f3 = ins[14:12];
        if (ins[6:0] == cop_pkg::OPC_FP) begin
            if (f3 == cop_pkg::F3_MUL_LO || f3 == cop_pkg::F3_MUL_HI) begin
                return DW + 1;
            end
            return 1;
        end
        if (ins[6:0] == cop_pkg::OPC_CUSTOM) begin
            return 2;
        end
        return 1;
    endfunction

    task automatic report_mismatch(input string what, input logic [DW-1:0] got,
                                   input logic [DW-1:0] exp);
        $display("Error at %0t: test %0d %s is 0x%0h, expected 0x%0h",
                 $time, cur_test, what, got, exp);
        test_ok = 1'b0;
    endtask

    // Holds the instruction until the result, then checks the register write
    task automatic run_coprocessor_test(input int kind, input logic [31:0] ins,
                                        input logic [DW-1:0] a, input logic [DW-1:0] b,
                                        input logic [DW-1:0] exp_res, output bit timed_out);
        int         cycles;
        bit         got;
        logic [4:0] rd;
        rd        = ins[11:7];
        timed_out = 1'b0;
        got       = 1'b0;
        cycles    = 0;
        @(posedge clk);
        instruction <= ins;
        rs1_data    <= a;
        rs2_data    <= b;
        inst_valid  <= 1'b1;
        while (!got && cycles < TIMEOUT) begin
            @(negedge clk);
            if (cp_instruction_detected !== 1'b1) begin
                report_mismatch("cp_instruction_detected", cp_instruction_detected, 1);
            end
            if (cp_result_valid) begin
                got = 1'b1;
            end else begin
                if (cp_stall_request !== 1'b1) begin
                    report_mismatch("cp_stall_request before result", cp_stall_request, 1);
                end
                cycles++;
            end
        end
        if (!got) begin
            $display("Timeout: test %0d got no result within %0d cycles", cur_test, TIMEOUT);
            timed_out = 1'b1;
            test_ok   = 1'b0;
        end else begin
            if (cycles != expected_latency(ins)) begin
                report_mismatch("latency", cycles, expected_latency(ins));
            end
            if (cp_stall_request !== 1'b0) begin
                report_mismatch("cp_stall_request at result", cp_stall_request, 0);
            end
            if (cp_exception_out !== (kind == 1)) begin
                report_mismatch("cp_exception_out", cp_exception_out, kind == 1);
            end
            if (kind == 0 && cp_result !== exp_res) begin
                report_mismatch("cp_result", cp_result, exp_res);
            end
        end
        @(posedge clk);
        inst_valid <= 1'b0;
        @(negedge clk);
        if (got) begin
            if (kind == 0 && rd != 5'd0) begin
                if (cp_reg_write !== 1'b1) begin
                    report_mismatch("cp_reg_write", cp_reg_write, 1);
                end
                if (cp_reg_addr !== rd) begin
                    report_mismatch("cp_reg_addr", cp_reg_addr, rd);
                end
                if (cp_reg_data !== exp_res) begin
                    report_mismatch("cp_reg_data", cp_reg_data, exp_res);
                end
            end else if (cp_reg_write !== 1'b0) begin
                report_mismatch("cp_reg_write", cp_reg_write, 0);
            end
        end
    endtask

    // Instruction that must be ignored, either by opcode or by pipeline_stall
    task automatic run_quiet_test(input int kind, input logic [31:0] ins,
                                  input logic [DW-1:0] a, input logic [DW-1:0] b);
        @(posedge clk);
        instruction    <= ins;
        rs1_data       <= a;
        rs2_data       <= b;
        inst_valid     <= 1'b1;
        pipeline_stall <= (kind == 3);
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            if (cp_instruction_detected || cp_stall_request || cp_result_valid ||
                cp_reg_write) begin
                $display("Error at %0t: test %0d got a response to an ignored instruction",
                         $time, cur_test);
                test_ok = 1'b0;
            end
        end
        @(posedge clk);
        inst_valid     <= 1'b0;
        pipeline_stall <= 1'b0;
    endtask

    initial begin
        int            fd;
        int            n;
        int            tnum;
        int            kind;
        int            gap;
        string         line;
        logic [31:0]   ins;
        logic [DW-1:0] a;
        logic [DW-1:0] b;
        logic [DW-1:0] exp_res;
        bit            timed_out;
        bit            aborted;
        bit            chk_failed;
        clk            = 1'b0;
        rst_n          = 1'b0;
        instruction    = '0;
        inst_valid     = 1'b0;
        rs1_data       = '0;
        rs2_data       = '0;
        pipeline_stall = 1'b0;
        pass_count     = 0;
        fail_count     = 0;
        aborted        = 1'b0;
        void'($urandom(19));
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        fd = $fopen("dv/cop_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file dv/cop_testdata.txt");
            fail_count++;
        end else begin
            while (!aborted && $fgets(line, fd) != 0) begin
                // Comment and blank lines do not scan
                n = $sscanf(line, "%d %h %h %h %h %d", tnum, ins, a, b, exp_res, kind);
                if (n == 6) begin
                    cur_test  = tnum;
                    test_ok   = 1'b1;
                    timed_out = 1'b0;
                    if (kind >= 2) begin
                        run_quiet_test(kind, ins, a, b);
                    end else begin
                        run_coprocessor_test(kind, ins, a, b, exp_res, timed_out);
                    end
                    if (test_ok) begin
                        $display("Test %0d passed", tnum);
                        pass_count++;
                    end else begin
                        $display("Test %0d failed", tnum);
                        fail_count++;
                    end
                    aborted = timed_out;
                    gap = $urandom % 4;
                    repeat (gap) @(posedge clk);
                end
            end
            $fclose(fd);
        end

        chk_failed = (dut0.chk0.assert_fails != 0);
        if (chk_failed) begin
            $display("Protocol assertions failed %0d times", dut0.chk0.assert_fails);
        end
        $display("Tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && pass_count > 0 && !chk_failed) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/cop_testdata.txt ====
// Columns: test, instruction, rs1, rs2, expected result (hex), check
// Check: 0 result, 1 exception, 2 non-coprocessor opcode, 3 presented with pipeline_stall
1  341012F3 123456789ABCDEF0 0000000000000000 0000000000000000 0
2  34102373 0F00000000000001 0000000000000000 123456789ABCDEF0 0
3  341033F3 00000000FFFF0000 0000000000000000 1F3456789ABCDEF1 0
4  34102073 0000000000000000 0000000000000000 1F3456780000DEF1 0
5  343014F3 AAAA5555AAAA5555 0000000000000000 0000000000000000 0
6  34302573 0000000000000000 0000000000000000 AAAA5555AAAA5555 0
7  34401473 000000000000FFFF 0000000000000000 0000000000000000 1
8  000005D3 0000000100000003 0000000200000005 0000000B0000000F 0
9  00001653 0000000100000003 0000000200000005 0000000000000002 0
10 000016D3 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFE 0
11 00000753 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 0000000000000001 0
12 000027D3 0000000000000007 0000000000000003 0000000000000000 1
13 0000080B F0F0000000000001 0000000000000000 0000000000000009 0
14 0000188B 0000000000000001 0000000000000000 8000000000000000 0
15 00001A0B 00000000000000F3 0000000000000000 CF00000000000000 0
16 0000290B 0000000000001000 0000000000000000 0000000000000033 0
17 0000298B 0000000000000000 0000000000000000 0000000000000040 0
18 00003A8B 0000000000000005 0000000000000000 0000000000000000 1
19 00000333 0000000000000001 0000000000000002 0000000000000000 2
20 00A00093 0000000000000000 0000000000000000 0000000000000000 2
21 342010F3 000000000000DEAD 0000000000000000 0000000000000000 3
22 34202173 0000000000000000 0000000000000000 0000000000000000 0

// ==== tb.f ====
hdl/cop_pkg.sv
hdl/cop_dispatcher.sv
hdl/csr_unit.sv
hdl/mul_unit.sv
hdl/bitmanip_unit.sv
hdl/cop_writeback.sv
hdl/cop_subsystem.sv
dv/cop_subsystem_chk.sv
dv/cop_subsystem_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= cop_subsystem_tb
FILELIST  ?= tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := SOME TESTS FAILED

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
